//--- rtl/rvc_isa_pkg.sv
package rvc_isa_pkg;

    localparam int REG_IDX_W = 5;  // x0..x31
    localparam int INST_W    = 16;

    // quadrant in bits 1:0
    localparam logic [1:0] QUAD_0    = 2'd0;
    localparam logic [1:0] QUAD_1    = 2'd1;
    localparam logic [1:0] QUAD_2    = 2'd2;
    localparam logic [1:0] QUAD_FULL = 2'd3; // 32-bit instruction, not ours

    localparam logic [REG_IDX_W-1:0] REG_ZERO = 5'd0;
    localparam logic [REG_IDX_W-1:0] REG_RA   = 5'd1;
    localparam logic [REG_IDX_W-1:0] REG_SP   = 5'd2;

    // 3-bit register fields only reach x8..x15
    localparam logic [1:0] CREG_BASE = 2'b01;

    // funct3, quadrant 0
    localparam logic [2:0] F3_ADDI4SPN = 3'd0;
    localparam logic [2:0] F3_LW       = 3'd2;
    localparam logic [2:0] F3_SW       = 3'd6;

    // funct3, quadrant 1
    localparam logic [2:0] F3_ADDI     = 3'd0;
    localparam logic [2:0] F3_JAL      = 3'd1;
    localparam logic [2:0] F3_LI       = 3'd2;
    localparam logic [2:0] F3_LUI      = 3'd3; // also ADDI16SP when rd is x2
    localparam logic [2:0] F3_MISC_ALU = 3'd4;
    localparam logic [2:0] F3_J        = 3'd5;
    localparam logic [2:0] F3_BEQZ     = 3'd6;
    localparam logic [2:0] F3_BNEZ     = 3'd7;

    // funct3, quadrant 2
    localparam logic [2:0] F3_SLLI     = 3'd0;
    localparam logic [2:0] F3_LWSP     = 3'd2;
    localparam logic [2:0] F3_CR       = 3'd4; // JR/JALR/MV/ADD
    localparam logic [2:0] F3_SWSP     = 3'd6;

    // funct2 in bits 11:10 of the misc-alu group
    localparam logic [1:0] F2_SRLI  = 2'd0;
    localparam logic [1:0] F2_SRAI  = 2'd1;
    localparam logic [1:0] F2_ANDI  = 2'd2;
    localparam logic [1:0] F2_ARITH = 2'd3;

endpackage

//--- rtl/rvc_ctrl_pkg.sv
package rvc_ctrl_pkg;

    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LUI
    } op_class_t;

    // ten layouts, so four bits
    typedef enum logic [3:0] {
        FMT_CI,       // 6-bit signed
        FMT_CI_SHAMT,
        FMT_CI_LUI,
        FMT_CI_SP16,
        FMT_CIW_SPN,
        FMT_CL_CS,
        FMT_LWSP,
        FMT_SWSP,
        FMT_CJ,
        FMT_CB
    } imm_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_AND = 4'd3,
        ALU_OR  = 4'd4,
        ALU_XOR = 4'd5,
        ALU_SLL = 4'd8,
        ALU_SRL = 4'd9,
        ALU_SRA = 4'd10
    } alu_op_t;

    localparam logic [2:0] IMM_SEL_I = 3'd0;
    localparam logic [2:0] IMM_SEL_S = 3'd1;
    localparam logic [2:0] IMM_SEL_U = 3'd2;
    localparam logic [2:0] IMM_SEL_B = 3'd3;
    localparam logic [2:0] IMM_SEL_J = 3'd4;

    // write-back source
    localparam logic [1:0] DATA_SEL_PC_PLUS = 2'd0;
    localparam logic [1:0] DATA_SEL_ALU     = 2'd1;
    localparam logic [1:0] DATA_SEL_IMM     = 2'd2;
    localparam logic [1:0] DATA_SEL_MEM     = 2'd3;

    localparam logic [1:0] DM_WORD = 2'd2;

endpackage

//--- rtl/rvc_field_decode.sv
module rvc_field_decode (
    input  logic [rvc_isa_pkg::INST_W-1:0]    i_inst,
    output rvc_ctrl_pkg::op_class_t           o_op_class,
    output rvc_ctrl_pkg::imm_fmt_t            o_imm_fmt,
    output rvc_ctrl_pkg::alu_op_t             o_alu_op,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rs1,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rs2,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rd
);

    logic [1:0] quadrant;
    logic [2:0] funct3;
    logic       funct4;    // bit 12
    logic [1:0] funct2;
    logic [1:0] funct2_lo;
    logic [rvc_isa_pkg::REG_IDX_W-1:0] rd_full;
    logic [rvc_isa_pkg::REG_IDX_W-1:0] rs2_full;
    logic [rvc_isa_pkg::REG_IDX_W-1:0] creg_a;  // from bits 9:7
    logic [rvc_isa_pkg::REG_IDX_W-1:0] creg_b;  // from bits 4:2

    assign quadrant  = i_inst[1:0];
    assign funct3    = i_inst[15:13];
    assign funct4    = i_inst[12];
    assign funct2    = i_inst[11:10];
    assign funct2_lo = i_inst[6:5];
    assign rd_full   = i_inst[11:7];
    assign rs2_full  = i_inst[6:2];
    assign creg_a    = {rvc_isa_pkg::CREG_BASE, i_inst[9:7]};
    assign creg_b    = {rvc_isa_pkg::CREG_BASE, i_inst[4:2]};

    always_comb begin
        o_op_class = rvc_ctrl_pkg::CLS_NONE;
        o_imm_fmt  = rvc_ctrl_pkg::FMT_CI;
        o_alu_op   = rvc_ctrl_pkg::ALU_ADD;
        o_rs1      = rvc_isa_pkg::REG_ZERO;
        o_rs2      = rvc_isa_pkg::REG_ZERO;
        o_rd       = rvc_isa_pkg::REG_ZERO;

        case (quadrant)
            rvc_isa_pkg::QUAD_0: begin
                case (funct3)
                    rvc_isa_pkg::F3_ADDI4SPN: begin
                        if (i_inst[12:5] != '0) begin  // zero imm is reserved, covers 0x0000
                            o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                            o_imm_fmt  = rvc_ctrl_pkg::FMT_CIW_SPN;
                            o_rd       = creg_b;
                            o_rs1      = rvc_isa_pkg::REG_SP;
                        end
                    end
                    rvc_isa_pkg::F3_LW: begin
                        o_op_class = rvc_ctrl_pkg::CLS_LOAD;
                        o_imm_fmt  = rvc_ctrl_pkg::FMT_CL_CS;
                        o_rd       = creg_b;
                        o_rs1      = creg_a;
                    end
                    rvc_isa_pkg::F3_SW: begin
                        o_op_class = rvc_ctrl_pkg::CLS_STORE;
                        o_imm_fmt  = rvc_ctrl_pkg::FMT_CL_CS;
                        o_rs1      = creg_a;
                        o_rs2      = creg_b;
                    end
                    default: ;
                endcase
            end
            rvc_isa_pkg::QUAD_1: begin
                case (funct3)
                    rvc_isa_pkg::F3_ADDI: begin
                        o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                        o_rd       = rd_full;
                        o_rs1      = rd_full;
                    end
                    rvc_isa_pkg::F3_JAL, rvc_isa_pkg::F3_J: begin
                        o_op_class = rvc_ctrl_pkg::CLS_JAL;
                        o_imm_fmt  = rvc_ctrl_pkg::FMT_CJ;
                        // only JAL links
                        o_rd       = (funct3 == rvc_isa_pkg::F3_JAL) ? rvc_isa_pkg::REG_RA
                                                                     : rvc_isa_pkg::REG_ZERO;
                    end
                    rvc_isa_pkg::F3_LI: begin
                        o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                        o_rd       = rd_full;   // rs1 stays x0
                    end
                    rvc_isa_pkg::F3_LUI: begin
                        if (rd_full == rvc_isa_pkg::REG_SP) begin  // ADDI16SP
                            o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                            o_imm_fmt  = rvc_ctrl_pkg::FMT_CI_SP16;
                            o_rd       = rvc_isa_pkg::REG_SP;
                            o_rs1      = rvc_isa_pkg::REG_SP;
                        end else begin
                            o_op_class = rvc_ctrl_pkg::CLS_LUI;
                            o_imm_fmt  = rvc_ctrl_pkg::FMT_CI_LUI;
                            o_rd       = rd_full;
                        end
                    end
                    rvc_isa_pkg::F3_MISC_ALU: begin
                        o_rd  = creg_a;
                        o_rs1 = creg_a;
                        case (funct2)
                            rvc_isa_pkg::F2_SRLI: begin
                                o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                                o_imm_fmt  = rvc_ctrl_pkg::FMT_CI_SHAMT;
                                o_alu_op   = rvc_ctrl_pkg::ALU_SRL;
                            end
                            rvc_isa_pkg::F2_SRAI: begin
                                o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                                o_imm_fmt  = rvc_ctrl_pkg::FMT_CI_SHAMT;
                                o_alu_op   = rvc_ctrl_pkg::ALU_SRA;
                            end
                            rvc_isa_pkg::F2_ANDI: begin
                                o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                                o_alu_op   = rvc_ctrl_pkg::ALU_AND;
                            end
                            default: begin
                                if (!funct4) begin  // funct4 set means RV64 ops
                                    o_op_class = rvc_ctrl_pkg::CLS_ALU_REG;
                                    o_rs2      = creg_b;
                                    case (funct2_lo)
                                        2'd0:    o_alu_op = rvc_ctrl_pkg::ALU_SUB;
                                        2'd1:    o_alu_op = rvc_ctrl_pkg::ALU_XOR;
                                        2'd2:    o_alu_op = rvc_ctrl_pkg::ALU_OR;
                                        default: o_alu_op = rvc_ctrl_pkg::ALU_AND;
                                    endcase
                                end
                            end
                        endcase
                    end
                    default: begin  // BEQZ/BNEZ compare against x0
                        o_op_class = rvc_ctrl_pkg::CLS_BRANCH;
                        o_imm_fmt  = rvc_ctrl_pkg::FMT_CB;
                        o_alu_op   = rvc_ctrl_pkg::ALU_SUB;
                        o_rs1      = creg_a;
                    end
                endcase
            end
            rvc_isa_pkg::QUAD_2: begin
                case (funct3)
                    rvc_isa_pkg::F3_SLLI: begin
                        o_op_class = rvc_ctrl_pkg::CLS_ALU_IMM;
                        o_imm_fmt  = rvc_ctrl_pkg::FMT_CI_SHAMT;
                        o_alu_op   = rvc_ctrl_pkg::ALU_SLL;
                        o_rd       = rd_full;
                        o_rs1      = rd_full;
                    end
                    rvc_isa_pkg::F3_LWSP: begin
                        o_op_class = rvc_ctrl_pkg::CLS_LOAD;
                        o_imm_fmt  = rvc_ctrl_pkg::FMT_LWSP;
                        o_rd       = rd_full;
                        o_rs1      = rvc_isa_pkg::REG_SP;
                    end
                    rvc_isa_pkg::F3_SWSP: begin
                        o_op_class = rvc_ctrl_pkg::CLS_STORE;
                        o_imm_fmt  = rvc_ctrl_pkg::FMT_SWSP;
                        o_rs1      = rvc_isa_pkg::REG_SP;
                        o_rs2      = rs2_full;
                    end
                    rvc_isa_pkg::F3_CR: begin
                        if (rs2_full != rvc_isa_pkg::REG_ZERO) begin
                            // ADD when funct4 set, else MV reading x0
                            o_op_class = rvc_ctrl_pkg::CLS_ALU_REG;
                            o_rd       = rd_full;
                            o_rs1      = funct4 ? rd_full : rvc_isa_pkg::REG_ZERO;
                            o_rs2      = rs2_full;
                        end else if (rd_full != rvc_isa_pkg::REG_ZERO) begin  // not EBREAK
                            o_op_class = rvc_ctrl_pkg::CLS_JALR;
                            o_rs1      = rd_full;
                            o_rd       = funct4 ? rvc_isa_pkg::REG_RA : rvc_isa_pkg::REG_ZERO;
                        end
                    end
                    default: ;
                endcase
            end
            default: ;  // full-width instruction
        endcase

        // undecoded encodings carry no indices
        if (o_op_class == rvc_ctrl_pkg::CLS_NONE) begin
            o_rs1 = rvc_isa_pkg::REG_ZERO;
            o_rs2 = rvc_isa_pkg::REG_ZERO;
            o_rd  = rvc_isa_pkg::REG_ZERO;
        end
    end

endmodule

//--- rtl/rvc_ctrl_gen.sv
module rvc_ctrl_gen (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_valid,
    input  logic [1:0]                        i_quadrant,
    input  rvc_ctrl_pkg::op_class_t           i_op_class,
    input  rvc_ctrl_pkg::alu_op_t             i_alu_op,
    input  logic [rvc_isa_pkg::REG_IDX_W-1:0] i_rs1,
    input  logic [rvc_isa_pkg::REG_IDX_W-1:0] i_rs2,
    input  logic [rvc_isa_pkg::REG_IDX_W-1:0] i_rd,
    output logic                              o_valid,
    output logic                              o_is_compressed,
    output logic                              o_wr_en,
    output logic                              o_is_store,
    output logic                              o_is_branch,
    output logic                              o_is_jump,
    output logic                              o_sel_op_a,
    output logic                              o_sel_op_b,
    output logic [2:0]                        o_dm_select,
    output logic [2:0]                        o_imm_select,
    output logic [1:0]                        o_sel_data,
    output rvc_ctrl_pkg::alu_op_t             o_alu_op,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rs1,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rs2,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rd
);

    logic is_alu_imm, is_load, is_store, is_branch, is_jal, is_jalr, is_lui, is_reg;
    logic       wr_en_nxt;
    logic [2:0] imm_sel_nxt;
    logic [1:0] sel_data_nxt;

    assign is_alu_imm = (i_op_class == rvc_ctrl_pkg::CLS_ALU_IMM);
    assign is_load    = (i_op_class == rvc_ctrl_pkg::CLS_LOAD);
    assign is_store   = (i_op_class == rvc_ctrl_pkg::CLS_STORE);
    assign is_branch  = (i_op_class == rvc_ctrl_pkg::CLS_BRANCH);
    assign is_jal     = (i_op_class == rvc_ctrl_pkg::CLS_JAL);
    assign is_jalr    = (i_op_class == rvc_ctrl_pkg::CLS_JALR);
    assign is_lui     = (i_op_class == rvc_ctrl_pkg::CLS_LUI);
    assign is_reg     = (i_op_class == rvc_ctrl_pkg::CLS_ALU_REG);

    // only classes that write a register
    assign wr_en_nxt = is_alu_imm || is_reg || is_load || is_jal || is_jalr || is_lui;

    assign imm_sel_nxt  = is_jal    ? rvc_ctrl_pkg::IMM_SEL_J :
                          is_branch ? rvc_ctrl_pkg::IMM_SEL_B :
                          is_lui    ? rvc_ctrl_pkg::IMM_SEL_U :
                          is_store  ? rvc_ctrl_pkg::IMM_SEL_S : rvc_ctrl_pkg::IMM_SEL_I;
    assign sel_data_nxt = (is_jal || is_jalr) ? rvc_ctrl_pkg::DATA_SEL_PC_PLUS :
                          is_lui              ? rvc_ctrl_pkg::DATA_SEL_IMM :
                          is_load             ? rvc_ctrl_pkg::DATA_SEL_MEM :
                                                rvc_ctrl_pkg::DATA_SEL_ALU;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid         <= 1'b0;
            o_is_compressed <= 1'b0;
            o_wr_en         <= 1'b0;
            o_is_store      <= 1'b0;
            o_is_branch     <= 1'b0;
            o_is_jump       <= 1'b0;
            o_sel_op_a      <= 1'b0;
            o_sel_op_b      <= 1'b0;
            o_dm_select     <= '0;
            o_imm_select    <= '0;
            o_sel_data      <= '0;
            o_alu_op        <= rvc_ctrl_pkg::alu_op_t'(4'd0);
            o_rs1           <= '0;
            o_rs2           <= '0;
            o_rd            <= '0;
        end else begin
            o_valid         <= i_valid;
            o_is_compressed <= (i_quadrant != rvc_isa_pkg::QUAD_FULL);
            o_wr_en         <= wr_en_nxt;
            o_is_store      <= is_store;
            o_is_branch     <= is_branch;
            o_is_jump       <= is_jal || is_jalr;
            o_sel_op_a      <= !(is_lui || is_jal);    // pc or zero base
            o_sel_op_b      <= !(is_reg || is_branch); // immediate operand
            o_dm_select     <= (is_load || is_store) ? {1'b0, rvc_ctrl_pkg::DM_WORD} : 3'd0;
            o_imm_select    <= imm_sel_nxt;
            o_sel_data      <= sel_data_nxt;
            o_alu_op        <= i_alu_op;
            o_rs1           <= i_rs1;
            o_rs2           <= i_rs2;
            o_rd            <= i_rd;
        end
    end

    a_no_wr_on_store: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_wr_en && o_is_store));

    a_valid_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        !$isunknown(o_valid));

endmodule

//--- rtl/rvc_imm_gen.sv
module rvc_imm_gen #(
    parameter int P_XLEN = 32
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic [rvc_isa_pkg::INST_W-1:0] i_inst,
    input  rvc_ctrl_pkg::imm_fmt_t         i_imm_fmt,
    output logic [P_XLEN-1:0]              o_imm,
    output logic [P_XLEN-1:0]              o_jump_ofs
);

    logic [P_XLEN-1:0] imm_nxt;
    logic [P_XLEN-1:0] ofs_nxt;
    logic [11:0]       cj_ofs;   // offset[11:0]
    logic [8:0]        cb_ofs;   // offset[8:0]

    // scrambled offset fields, bit 0 always zero
    assign cj_ofs = {i_inst[12], i_inst[8], i_inst[10:9], i_inst[6], i_inst[7],
                     i_inst[2], i_inst[11], i_inst[5:3], 1'b0};
    assign cb_ofs = {i_inst[12], i_inst[6:5], i_inst[2], i_inst[11:10], i_inst[4:3], 1'b0};

    always_comb begin
        case (i_imm_fmt)
            rvc_ctrl_pkg::FMT_CI_SHAMT:
                imm_nxt = P_XLEN'({i_inst[12], i_inst[6:2]});
            rvc_ctrl_pkg::FMT_CI_LUI:  // nzimm[17:12]
                imm_nxt = P_XLEN'($signed({i_inst[12], i_inst[6:2], 12'd0}));
            rvc_ctrl_pkg::FMT_CI_SP16: // nzimm[9:4]
                imm_nxt = P_XLEN'($signed({i_inst[12], i_inst[4:3], i_inst[5], i_inst[2],
                                           i_inst[6], 4'd0}));
            rvc_ctrl_pkg::FMT_CIW_SPN: // nzuimm[9:2]
                imm_nxt = P_XLEN'({i_inst[10:7], i_inst[12:11], i_inst[5], i_inst[6], 2'd0});
            rvc_ctrl_pkg::FMT_CL_CS:   // uimm[6:2]
                imm_nxt = P_XLEN'({i_inst[5], i_inst[12:10], i_inst[6], 2'd0});
            rvc_ctrl_pkg::FMT_LWSP:    // uimm[7:2]
                imm_nxt = P_XLEN'({i_inst[3:2], i_inst[12], i_inst[6:4], 2'd0});
            rvc_ctrl_pkg::FMT_SWSP:
                imm_nxt = P_XLEN'({i_inst[8:7], i_inst[12:9], 2'd0});
            rvc_ctrl_pkg::FMT_CJ:
                imm_nxt = P_XLEN'($signed(cj_ofs));
            rvc_ctrl_pkg::FMT_CB:
                imm_nxt = P_XLEN'($signed(cb_ofs));
            default:                   // plain CI, 6-bit signed
                imm_nxt = P_XLEN'($signed({i_inst[12], i_inst[6:2]}));
        endcase
    end

    // branch layout unless it is a jump
    assign ofs_nxt = (i_imm_fmt == rvc_ctrl_pkg::FMT_CJ) ? P_XLEN'($signed(cj_ofs))
                                                         : P_XLEN'($signed(cb_ofs));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_imm      <= '0;
            o_jump_ofs <= '0;
        end else begin
            o_imm      <= imm_nxt;
            o_jump_ofs <= ofs_nxt;
        end
    end

    // scaled word offsets land word aligned on the next cycle
    a_word_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_imm_fmt inside {rvc_ctrl_pkg::FMT_CIW_SPN, rvc_ctrl_pkg::FMT_CL_CS,
                          rvc_ctrl_pkg::FMT_LWSP, rvc_ctrl_pkg::FMT_SWSP}
        |=> o_imm[1:0] == 2'b00);

endmodule

//--- rtl/rvc_decoder_top.sv
module rvc_decoder_top #(
    parameter int P_XLEN = 32
) (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_valid,
    input  logic [rvc_isa_pkg::INST_W-1:0]    i_inst,
    output logic                              o_valid,
    output logic                              o_is_compressed,
    output logic                              o_wr_en,
    output logic                              o_is_store,
    output logic                              o_is_branch,
    output logic                              o_is_jump,
    output logic                              o_sel_op_a,
    output logic                              o_sel_op_b,
    output logic [2:0]                        o_dm_select,
    output logic [2:0]                        o_imm_select,
    output logic [1:0]                        o_sel_data,
    output rvc_ctrl_pkg::alu_op_t             o_alu_op,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rs1,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rs2,
    output logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rd,
    output logic [P_XLEN-1:0]                 o_imm,
    output logic [P_XLEN-1:0]                 o_jump_ofs
);

    rvc_ctrl_pkg::op_class_t           dec_class;
    rvc_ctrl_pkg::imm_fmt_t            dec_imm_fmt;
    rvc_ctrl_pkg::alu_op_t             dec_alu_op;
    logic [rvc_isa_pkg::REG_IDX_W-1:0] dec_rs1;
    logic [rvc_isa_pkg::REG_IDX_W-1:0] dec_rs2;
    logic [rvc_isa_pkg::REG_IDX_W-1:0] dec_rd;

    rvc_field_decode field_decode_i (
        .i_inst     (i_inst),
        .o_op_class (dec_class),
        .o_imm_fmt  (dec_imm_fmt),
        .o_alu_op   (dec_alu_op),
        .o_rs1      (dec_rs1),
        .o_rs2      (dec_rs2),
        .o_rd       (dec_rd)
    );

    rvc_ctrl_gen ctrl_gen_i (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (i_valid),
        .i_quadrant      (i_inst[1:0]),
        .i_op_class      (dec_class),
        .i_alu_op        (dec_alu_op),
        .i_rs1           (dec_rs1),
        .i_rs2           (dec_rs2),
        .i_rd            (dec_rd),
        .o_valid         (o_valid),
        .o_is_compressed (o_is_compressed),
        .o_wr_en         (o_wr_en),
        .o_is_store      (o_is_store),
        .o_is_branch     (o_is_branch),
        .o_is_jump       (o_is_jump),
        .o_sel_op_a      (o_sel_op_a),
        .o_sel_op_b      (o_sel_op_b),
        .o_dm_select     (o_dm_select),
        .o_imm_select    (o_imm_select),
        .o_sel_data      (o_sel_data),
        .o_alu_op        (o_alu_op),
        .o_rs1           (o_rs1),
        .o_rs2           (o_rs2),
        .o_rd            (o_rd)
    );

    rvc_imm_gen #(
        .P_XLEN (P_XLEN)
    ) imm_gen_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_inst     (i_inst),
        .i_imm_fmt  (dec_imm_fmt),
        .o_imm      (o_imm),
        .o_jump_ofs (o_jump_ofs)
    );

endmodule

//--- verif/rvc_decoder_tb.sv
module rvc_decoder_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    localparam int MAX_VEC    = 64;
    localparam int N_COLS     = 10;  // expected columns after the halfword

    logic        clk;
    logic        i_rst_n;
    logic        i_valid;
    logic [15:0] i_inst;
    logic        o_valid, o_is_compressed, o_wr_en, o_is_store, o_is_branch, o_is_jump;
    logic        o_sel_op_a, o_sel_op_b;
    logic [2:0]  o_dm_select, o_imm_select;
    logic [1:0]  o_sel_data;
    rvc_ctrl_pkg::alu_op_t o_alu_op;
    logic [rvc_isa_pkg::REG_IDX_W-1:0] o_rs1, o_rs2, o_rd;
    logic [31:0] o_imm, o_jump_ofs;

    logic [15:0] vec_inst [MAX_VEC];
    logic [31:0] vec_exp  [MAX_VEC][N_COLS];
    int          n_vec = 0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cur_idx = 0;
    int          pend_q[$];      // vectors whose result is due next
    logic        monitor_on = 1'b0;
    logic [15:0] lfsr;

    rvc_decoder_top #(
        .P_XLEN (32)
    ) dut_i (
        .clk (clk), .i_rst_n (i_rst_n), .i_valid (i_valid), .i_inst (i_inst),
        .o_valid (o_valid), .o_is_compressed (o_is_compressed), .o_wr_en (o_wr_en),
        .o_is_store (o_is_store), .o_is_branch (o_is_branch), .o_is_jump (o_is_jump),
        .o_sel_op_a (o_sel_op_a), .o_sel_op_b (o_sel_op_b), .o_dm_select (o_dm_select),
        .o_imm_select (o_imm_select), .o_sel_data (o_sel_data), .o_alu_op (o_alu_op),
        .o_rs1 (o_rs1), .o_rs2 (o_rs2), .o_rd (o_rd),
        .o_imm (o_imm), .o_jump_ofs (o_jump_ofs)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [N_COLS+1];
        fd = $fopen("verif/rvc_decode_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verif/rvc_decode_vectors.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    if (n == N_COLS + 1) begin
                        vec_inst[n_vec] = f[0][15:0];
                        for (int c = 0; c < N_COLS; c++)
                            vec_exp[n_vec][c] = f[c+1];
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = err_cnt;
        check_field("o_valid", 32'd0, 32'(o_valid));
        check_field("o_wr_en", 32'd0, 32'(o_wr_en));
        check_field("o_is_store", 32'd0, 32'(o_is_store));
        check_field("o_is_branch", 32'd0, 32'(o_is_branch));
        check_field("o_is_jump", 32'd0, 32'(o_is_jump));
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test reset: ok");
        end else begin
            fail_cnt++;
            $display("test reset: FAILED");
        end
    endtask

    task automatic check_vector(input int idx);
        int          errs_before;
        logic [31:0] sd;
        logic [31:0] isel;
        logic        reg_op;
        logic [31:0] dm_exp;
        errs_before = err_cnt;
        sd     = vec_exp[idx][3];
        isel   = vec_exp[idx][4];
        reg_op = (vec_exp[idx][1] == 32'd1) && (vec_exp[idx][6] != 32'd0); // writes, reads rs2
        dm_exp = (sd == 32'd3 || isel == 32'd1) ? 32'(rvc_ctrl_pkg::DM_WORD) : 32'd0;
        check_field("o_is_compressed", vec_exp[idx][0], 32'(o_is_compressed));
        check_field("o_wr_en", vec_exp[idx][1], 32'(o_wr_en));
        check_field("o_alu_op", vec_exp[idx][2], 32'(o_alu_op));
        check_field("o_sel_data", sd, 32'(o_sel_data));
        check_field("o_imm_select", isel, 32'(o_imm_select));
        check_field("o_rs1", vec_exp[idx][5], 32'(o_rs1));
        check_field("o_rs2", vec_exp[idx][6], 32'(o_rs2));
        check_field("o_rd", vec_exp[idx][7], 32'(o_rd));
        check_field("o_imm", vec_exp[idx][8], o_imm);
        check_field("o_jump_ofs", vec_exp[idx][9], o_jump_ofs);
        // class flags follow from the select codes
        check_field("o_is_store", 32'(isel == 32'd1), 32'(o_is_store));
        check_field("o_is_branch", 32'(isel == 32'd3), 32'(o_is_branch));
        check_field("o_is_jump", 32'(sd == 32'd0), 32'(o_is_jump));
        // operand and memory selects
        check_field("o_sel_op_a", 32'(!(isel == 32'd2 || isel == 32'd4)), 32'(o_sel_op_a));
        check_field("o_sel_op_b", 32'(!(isel == 32'd3 || reg_op)), 32'(o_sel_op_b));
        check_field("o_dm_select", dm_exp, 32'(o_dm_select));
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d (%h): ok", idx, vec_inst[idx]);
        end else begin
            fail_cnt++;
            $display("test %0d (%h): FAILED", idx, vec_inst[idx]);
        end
    endtask

    task automatic run_stimulus();
        int          next;
        logic [15:0] idle_inst;
        next = 0;
        while (next < n_vec) begin
            @(posedge clk);
            #2;
            if (random_bit()) begin
                i_valid = 1'b1;
                i_inst  = vec_inst[next];
                cur_idx = next;
                next++;
            end else begin
                for (int b = 0; b < 16; b++)
                    idle_inst[b] = random_bit();
                i_valid = 1'b0;
                i_inst  = idle_inst;
            end
        end
        @(posedge clk);
        #2;
        i_valid = 1'b0;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (monitor_on && i_rst_n) begin
            check_field("o_valid", 32'(pend_q.size() != 0), 32'(o_valid));
            if (o_valid && pend_q.size() != 0)
                check_vector(pend_q.pop_front());
            if (i_valid)
                pend_q.push_back(cur_idx);
        end
    end

    initial begin
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_inst  = '0;
        lfsr    = 16'd41233;
        load_vectors();
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        @(negedge clk);
        check_reset();
        monitor_on = 1'b1;
        run_stimulus();
        @(posedge clk);
        while (pend_q.size() != 0)
            @(posedge clk);
        @(negedge clk);
        $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && n_vec > 0 && pass_cnt == n_vec + 1) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #1;  // vectors are in by now
        #((n_vec * 4 + RST_CYCLES) * CLK_PERIOD);
        $display("timeout: the decoder did not return all results in time");
        $display("sim failed");
        $finish;
    end

endmodule

//--- verif/rvc_decode_vectors.txt
# inst is_compressed wr_en alu_op sel_data imm_select rs1 rs2 rd imm jump_ofs
# all hex, one halfword per line
0040 1 1 1 1 0 02 00 08 00000004 00000080
1FE4 1 1 1 1 0 02 00 09 000003FC FFFFFFF8
4588 1 1 1 3 0 0B 00 0A 00000008 0000000A
5FFC 1 1 1 3 0 0F 00 0F 0000007C FFFFFFFE
C044 1 0 1 1 1 08 09 00 00000004 000000A0
0001 1 1 1 1 0 00 00 00 00000000 00000000
12FD 1 1 1 1 0 05 00 05 FFFFFFFF FFFFFFE6
2801 1 1 1 0 4 00 00 01 00000010 00000010
BFFD 1 1 1 0 4 00 00 00 FFFFFFFE FFFFFFFE
5501 1 1 1 1 0 00 00 0A FFFFFFE0 FFFFFF08
63FD 1 1 1 2 2 00 00 07 0001F000 000000E6
7185 1 1 1 2 2 00 00 03 FFFE1000 FFFFFF20
7139 1 1 1 1 0 02 00 02 FFFFFFC0 FFFFFF46
800D 1 1 9 1 0 08 00 08 00000003 00000022
84FD 1 1 A 1 0 09 00 09 0000001F 000000EE
9941 1 1 3 1 0 0A 00 0A FFFFFFF0 FFFFFF90
8C05 1 1 2 1 0 08 09 08 00000001 00000038
8DB1 1 1 5 1 0 0B 0C 0B 0000000C 0000005C
8ED9 1 1 4 1 0 0D 0E 0D 00000016 0000009E
8FE1 1 1 3 1 0 0F 08 0F 00000018 000000D8
C401 1 0 2 1 3 08 00 00 00000008 00000008
F081 1 0 2 1 3 09 00 00 FFFFFF00 FFFFFF00
0F86 1 1 8 1 0 1F 00 1F 00000001 00000038
50FE 1 1 1 3 0 02 00 01 000000FC FFFFFFE6
C096 1 0 1 1 1 02 05 00 00000040 00000024
8302 1 1 1 0 0 06 00 00 00000000 00000000
9382 1 1 1 0 0 07 00 01 FFFFFFE0 FFFFFF00
852E 1 1 1 1 0 00 0B 0A 0000000B 0000006A
952E 1 1 1 1 0 0A 0B 0A FFFFFFEB FFFFFF6A
0000 1 0 1 1 0 00 00 00 00000000 00000000
8000 1 0 1 1 0 00 00 00 00000000 00000000
9002 1 0 1 1 0 00 00 00 FFFFFFE0 FFFFFF00
9C05 1 0 1 1 0 00 00 00 FFFFFFE1 FFFFFF38
0013 0 0 1 1 0 00 00 00 00000004 00000004
FFFF 0 0 1 1 0 00 00 00 FFFFFFFF FFFFFFFE

//--- vlog.f
rtl/rvc_isa_pkg.sv
rtl/rvc_ctrl_pkg.sv
rtl/rvc_field_decode.sv
rtl/rvc_ctrl_gen.sv
rtl/rvc_imm_gen.sv
rtl/rvc_decoder_top.sv
verif/rvc_decoder_tb.sv
